//--- serial_slave_pkg.sv
/*
 Widths and types shared by every block of the bit-serial bus slave.
 Header bits arrive MSB first, so the start field ends up in the top bits.
 The header layout is start | id | rw | burst | addr, and rw = 1 means write.
*/
package serial_slave_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_DEPTH      = 256;
    localparam int ADDR_WIDTH      = $clog2(ADDR_DEPTH);
    localparam int ID_WIDTH        = 2;

    localparam int START_WIDTH     = 3;
    localparam logic [START_WIDTH-1:0] START_PATTERN = 3'b111;

    // start, id, rw, burst and address fields
    localparam int HDR_WIDTH       = START_WIDTH + ID_WIDTH + 2 + ADDR_WIDTH;

    // wide enough to count data bits, which also covers the header
    localparam int BIT_COUNT_WIDTH = $clog2(DATA_WIDTH + 1);

    // the same header word, seen as a shift register or as fields
    typedef union packed {
        logic [HDR_WIDTH-1:0] raw;
        struct packed {
            logic [START_WIDTH-1:0] start;
            logic [ID_WIDTH-1:0]    id;
            logic                   rw;
            logic                   burst;
            logic [ADDR_WIDTH-1:0]  addr;
        } f;
    } header_u;

    // transaction sequencing in slave_controller
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ_FETCH,
        READ_SEND
    } ctrl_state_e;

endpackage

//--- header_receiver.sv
/*
 Frames a serial header on control, starting at the first high bit seen
 while the slave is not busy.
 hdr_strobe pulses one cycle after the last header bit, and only when both
 the start code and the id match. Other headers are dropped silently.
*/
`timescale 1ns/100ps

module header_receiver #(
    parameter logic [serial_slave_pkg::ID_WIDTH-1:0] SLAVE_ID = 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      control,
    input  logic                      busy,
    output logic                      hdr_strobe,
    output serial_slave_pkg::header_u header
);

    logic                                         framing;
    logic [serial_slave_pkg::BIT_COUNT_WIDTH-1:0] bit_cnt;
    logic                                         start_hdr;
    logic                                         last_sample;
    logic                                         hdr_match;
    serial_slave_pkg::header_u                    next_hdr;

    // a new header can only begin while the controller is idle
    assign start_hdr   = !framing && !busy && control;
    assign last_sample = framing && (bit_cnt == serial_slave_pkg::HDR_WIDTH - 1);

    always_comb begin
        next_hdr.raw = {header.raw[serial_slave_pkg::HDR_WIDTH-2:0], control};
    end

    // compare on the word as it will look after the final shift
    assign hdr_match = (next_hdr.f.start == serial_slave_pkg::START_PATTERN) &&
                       (next_hdr.f.id == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            framing    <= 1'b0;
            bit_cnt    <= '0;
            hdr_strobe <= 1'b0;
        end else begin
            hdr_strobe <= 1'b0;
            if (start_hdr) begin
                framing <= 1'b1;
                bit_cnt <= bit_cnt + 1'b1;
            end else if (last_sample) begin
                framing    <= 1'b0;
                bit_cnt    <= '0;
                hdr_strobe <= hdr_match;
            end else if (framing) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // bits enter at the LSB, so the first one ends up in the start field
    always_ff @(posedge clk) begin
        if (start_hdr || framing) begin
            header <= next_hdr;
        end
    end

endmodule

//--- write_deserializer.sv
/*
 Collects write data from wD, one bit per cycle with valid high.
 Gaps in valid are allowed, and the count restarts whenever capture_en is low.
 word_strobe pulses the cycle after the last bit, with the word stable.
*/
`timescale 1ns/100ps

module write_deserializer (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    wD,
    input  logic                                    valid,
    input  logic                                    capture_en,
    output logic                                    word_strobe,
    output logic [serial_slave_pkg::DATA_WIDTH-1:0] word
);

    logic [serial_slave_pkg::BIT_COUNT_WIDTH-1:0] bit_cnt;
    logic                                         take_bit;
    logic                                         last_bit;

    assign take_bit = capture_en && valid;
    assign last_bit = (bit_cnt == serial_slave_pkg::DATA_WIDTH - 1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt     <= '0;
            word_strobe <= 1'b0;
        end else begin
            word_strobe <= 1'b0;
            if (!capture_en) begin
                bit_cnt <= '0;
            end else if (valid) begin
                if (last_bit) begin
                    bit_cnt     <= '0;
                    word_strobe <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // MSB first, so older bits move up
    always_ff @(posedge clk) begin
        if (take_bit) begin
            word <= {word[serial_slave_pkg::DATA_WIDTH-2:0], wD};
        end
    end

endmodule

//--- slave_controller.sv
/*
 Sequences one transaction per accepted header. Control is ignored until it ends.
 Writes commit one cycle after word_strobe. Reads fetch on the strobe or done
 cycle and load on the next one.
 Bursts end after the word in which last was seen, single transfers after one word.
*/
`timescale 1ns/100ps

module slave_controller (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    hdr_strobe,
    input  serial_slave_pkg::header_u               header,
    input  logic                                    word_strobe,
    input  logic [serial_slave_pkg::DATA_WIDTH-1:0] wr_word,
    input  logic                                    last,
    input  logic                                    done,
    output logic                                    busy,
    output logic                                    capture_en,
    output logic                                    mem_we,
    output logic [serial_slave_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [serial_slave_pkg::DATA_WIDTH-1:0] mem_wdata,
    output logic                                    load
);

    serial_slave_pkg::ctrl_state_e                state;
    logic [serial_slave_pkg::ADDR_WIDTH-1:0]      addr;
    logic                                         burst;
    logic                                         last_seen;

    assign busy = (state != serial_slave_pkg::IDLE);
    assign load = (state == serial_slave_pkg::READ_FETCH);

    // the first write bit may follow the header with no gap
    assign capture_en = (state == serial_slave_pkg::WRITE) ||
                        ((state == serial_slave_pkg::IDLE) && hdr_strobe && header.f.rw);

    // a read starts fetching in the strobe cycle itself
    assign mem_addr = hdr_strobe ? header.f.addr : addr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= serial_slave_pkg::IDLE;
            addr      <= '0;
            burst     <= 1'b0;
            last_seen <= 1'b0;
            mem_we    <= 1'b0;
        end else begin
            mem_we <= 1'b0;
            case (state)
                serial_slave_pkg::IDLE: begin
                    last_seen <= 1'b0;
                    if (hdr_strobe) begin
                        addr  <= header.f.addr;
                        burst <= header.f.burst;
                        state <= header.f.rw ? serial_slave_pkg::WRITE
                                             : serial_slave_pkg::READ_FETCH;
                    end
                end
                serial_slave_pkg::WRITE: begin
                    // step only after the committed word left the address
                    if (mem_we) begin
                        addr <= addr + 1'b1;
                    end
                    if (word_strobe) begin
                        mem_we <= 1'b1;
                        // the strobe cycle may already carry a bit of the next word
                        last_seen <= last;
                        if (!burst || last_seen) begin
                            state <= serial_slave_pkg::IDLE;
                        end
                    end else begin
                        last_seen <= last_seen | last;
                    end
                end
                serial_slave_pkg::READ_FETCH: begin
                    // point at the next word so it is fetched while this one is sent
                    addr  <= addr + 1'b1;
                    state <= serial_slave_pkg::READ_SEND;
                end
                serial_slave_pkg::READ_SEND: begin
                    if (done) begin
                        last_seen <= 1'b0;
                        if (!burst || last_seen || last) begin
                            state <= serial_slave_pkg::IDLE;
                        end else begin
                            state <= serial_slave_pkg::READ_FETCH;
                        end
                    end else begin
                        last_seen <= last_seen | last;
                    end
                end
                default: begin
                    state <= serial_slave_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (word_strobe) begin
            mem_wdata <= wr_word;
        end
    end

endmodule

//--- slave_memory.sv
/*
 Single-port word memory with a registered read.
 A read during a write returns the old word.
 Contents are undefined until they are written.
*/
`timescale 1ns/100ps

module slave_memory (
    input  logic                                    clk,
    input  logic                                    we,
    input  logic [serial_slave_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [serial_slave_pkg::DATA_WIDTH-1:0] wdata,
    output logic [serial_slave_pkg::DATA_WIDTH-1:0] rdata
);

    logic [serial_slave_pkg::DATA_WIDTH-1:0] mem [serial_slave_pkg::ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        // read every cycle, the controller decides when rdata matters
        rdata <= mem[addr];
    end

endmodule

//--- read_serializer.sv
/*
 Shifts a loaded word out on rD, MSB first, one bit per cycle.
 ready is high for exactly DATA_WIDTH cycles, and done marks the last one.
 The stream cannot be paused. A load while sending restarts with the new word.
*/
`timescale 1ns/100ps

module read_serializer (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    load,
    input  logic [serial_slave_pkg::DATA_WIDTH-1:0] word,
    output logic                                    rD,
    output logic                                    ready,
    output logic                                    done
);

    logic [serial_slave_pkg::DATA_WIDTH-1:0]      shift_q;
    logic [serial_slave_pkg::BIT_COUNT_WIDTH-1:0] bit_cnt;

    assign rD   = shift_q[serial_slave_pkg::DATA_WIDTH-1];
    assign done = ready && (bit_cnt == serial_slave_pkg::DATA_WIDTH - 1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // keeps rD low out of reset
            shift_q <= '0;
            bit_cnt <= '0;
            ready   <= 1'b0;
        end else if (load) begin
            shift_q <= word;
            bit_cnt <= '0;
            ready   <= 1'b1;
        end else if (ready) begin
            // zeros fill in behind, so rD settles low after the word
            shift_q <= {shift_q[serial_slave_pkg::DATA_WIDTH-2:0], 1'b0};
            if (done) begin
                bit_cnt <= '0;
                ready   <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- serial_slave_top.sv
/*
 Bit-serial bus slave: header receiver and write path in front, controller
 and memory in the middle, read serializer at the back.
 SLAVE_ID must be unique among the slaves that share one bus.
 The read stream has no back-pressure.
*/
`timescale 1ns/100ps

module serial_slave_top #(
    parameter logic [serial_slave_pkg::ID_WIDTH-1:0] SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    serial_slave_pkg::header_u               header;
    logic                                    hdr_strobe;
    logic                                    busy;
    logic                                    capture_en;
    logic                                    word_strobe;
    logic [serial_slave_pkg::DATA_WIDTH-1:0] wr_word;
    logic                                    mem_we;
    logic [serial_slave_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic [serial_slave_pkg::DATA_WIDTH-1:0] mem_wdata;
    logic [serial_slave_pkg::DATA_WIDTH-1:0] mem_rdata;
    logic                                    load;
    logic                                    done;

    header_receiver #(
        .SLAVE_ID (SLAVE_ID)
    ) u_header_receiver (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .busy       (busy),
        .hdr_strobe (hdr_strobe),
        .header     (header)
    );

    write_deserializer u_write_deserializer (
        .clk         (clk),
        .rstN        (rstN),
        .wD          (wD),
        .valid       (valid),
        .capture_en  (capture_en),
        .word_strobe (word_strobe),
        .word        (wr_word)
    );

    slave_controller u_slave_controller (
        .clk         (clk),
        .rstN        (rstN),
        .hdr_strobe  (hdr_strobe),
        .header      (header),
        .word_strobe (word_strobe),
        .wr_word     (wr_word),
        .last        (last),
        .done        (done),
        .busy        (busy),
        .capture_en  (capture_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .load        (load)
    );

    slave_memory u_slave_memory (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    read_serializer u_read_serializer (
        .clk   (clk),
        .rstN  (rstN),
        .load  (load),
        .word  (mem_rdata),
        .rD    (rD),
        .ready (ready),
        .done  (done)
    );

endmodule

//--- serial_slave_checker.sv
/*
 Assertions bound into slave_controller.
 done is the serializer's final ready bit, so it stands for the read stream here.
*/
`timescale 1ns/100ps

module serial_slave_checker (
    input logic                          clk,
    input logic                          rstN,
    input serial_slave_pkg::ctrl_state_e state,
    input logic                          busy,
    input logic                          load,
    input logic                          mem_we,
    input logic                          done
);

    // a word is either committed or loaded, never both at once
    no_write_during_load: assert property (
        @(posedge clk) disable iff (!rstN) !(mem_we && load)
    ) else $error("memory write and serializer load in the same cycle");

    // the last ready bit only while the controller is sending
    done_only_in_send: assert property (
        @(posedge clk) disable iff (!rstN) done |-> (state == serial_slave_pkg::READ_SEND)
    ) else $error("serializer done outside READ_SEND");

    idle_not_busy: assert property (
        @(posedge clk) disable iff (!rstN) (state == serial_slave_pkg::IDLE) |-> !busy
    ) else $error("busy is high in IDLE");

endmodule

//--- tb_serial_slave.sv
/*
 Table-driven testbench for serial_slave_top with SLAVE_ID 1.
 Expected read words come from a memory model that only accepted writes update.
 Reads only target addresses that an earlier entry wrote.
*/
`timescale 1ns/100ps

module tb_serial_slave;

    localparam logic [serial_slave_pkg::ID_WIDTH-1:0] SLAVE_ID = 1;
    localparam int MAX_BURST     = 4;
    localparam int NUM_ENTRIES   = 13;
    localparam int READY_TIMEOUT = 16;
    localparam int IDLE_WINDOW   = 40;

    typedef struct packed {
        logic                                         is_write;
        logic [serial_slave_pkg::START_WIDTH-1:0]     start;
        logic [serial_slave_pkg::ID_WIDTH-1:0]        id;
        logic [3:0]                                   len;
        logic [serial_slave_pkg::ADDR_WIDTH-1:0]      addr;
        logic                                         gaps;
        logic [MAX_BURST-1:0][serial_slave_pkg::DATA_WIDTH-1:0] wdata;
        logic [MAX_BURST-1:0][serial_slave_pkg::DATA_WIDTH-1:0] exp;
    } entry_t;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    int          errors;
    int          timeouts;
    int unsigned seed;
    entry_t      tbl [NUM_ENTRIES];
    logic [serial_slave_pkg::DATA_WIDTH-1:0] model [serial_slave_pkg::ADDR_DEPTH];

    serial_slave_top #(
        .SLAVE_ID (SLAVE_ID)
    ) uut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    bind slave_controller serial_slave_checker u_checker (
        .clk    (clk),
        .rstN   (rstN),
        .state  (state),
        .busy   (busy),
        .load   (load),
        .mem_we (mem_we),
        .done   (done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // inputs change and outputs are sampled 2 ns after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(input logic [serial_slave_pkg::DATA_WIDTH-1:0] got,
                              input logic [serial_slave_pkg::DATA_WIDTH-1:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic accepted(input entry_t e);
        return (e.start == serial_slave_pkg::START_PATTERN) && (e.id == SLAVE_ID);
    endfunction

    task automatic set_entry(input int idx, input logic is_write, input logic [2:0] start,
                             input logic [1:0] id, input int len, input logic [7:0] addr,
                             input logic gaps);
        int w;
        tbl[idx] = '0;
        tbl[idx].is_write = is_write;
        tbl[idx].start    = start;
        tbl[idx].id       = id;
        tbl[idx].len      = len;
        tbl[idx].addr     = addr;
        tbl[idx].gaps     = gaps;
        for (w = 0; w < MAX_BURST; w++) begin
            tbl[idx].wdata[w] = $urandom();
        end
    endtask

    task automatic build_table;
        set_entry(0, 1, 3'b111, 2'd1, 1, 8'h10, 0);
        set_entry(1, 0, 3'b111, 2'd1, 1, 8'h10, 0);
        // the neighbor word that the burst must not touch
        set_entry(2, 1, 3'b111, 2'd1, 1, 8'h44, 0);
        set_entry(3, 1, 3'b111, 2'd1, 4, 8'h40, 0);
        set_entry(4, 0, 3'b111, 2'd1, 4, 8'h40, 0);
        set_entry(5, 0, 3'b111, 2'd1, 1, 8'h44, 0);
        set_entry(6, 1, 3'b111, 2'd1, 1, 8'h20, 0);
        set_entry(7, 1, 3'b111, 2'd1, 1, 8'h21, 1);
        tbl[7].wdata = tbl[6].wdata;
        set_entry(8, 0, 3'b111, 2'd1, 2, 8'h20, 0);
        // headers for another slave or with a bad start code
        set_entry(9, 1, 3'b111, 2'd2, 1, 8'h10, 0);
        set_entry(10, 1, 3'b101, 2'd1, 1, 8'h10, 0);
        set_entry(11, 0, 3'b111, 2'd3, 1, 8'h10, 0);
        set_entry(12, 0, 3'b111, 2'd1, 1, 8'h10, 0);
    endtask

    task automatic fill_expected;
        int i;
        int w;
        for (i = 0; i < NUM_ENTRIES; i++) begin
            if (accepted(tbl[i])) begin
                for (w = 0; w < tbl[i].len; w++) begin
                    if (tbl[i].is_write) begin
                        model[tbl[i].addr + w] = tbl[i].wdata[w];
                    end else begin
                        tbl[i].exp[w] = model[tbl[i].addr + w];
                    end
                end
            end
        end
    endtask

    task automatic observe_idle(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_level(ready, 1'b0, "idle ready");
            check_level(rD, 1'b0, "idle rD");
        end
    endtask

    task automatic send_header(input entry_t e);
        logic [serial_slave_pkg::HDR_WIDTH-1:0] hdr;
        int i;
        hdr = {e.start, e.id, e.is_write, (e.len > 4'd1), e.addr};
        for (i = serial_slave_pkg::HDR_WIDTH - 1; i >= 0; i--) begin
            next_cycle();
            check_level(ready, 1'b0, "ready during header");
            control = hdr[i];
        end
        next_cycle();
        control = 1'b0;
    endtask

    task automatic write_words(input entry_t e);
        int w;
        int b;
        for (w = 0; w < e.len; w++) begin
            for (b = serial_slave_pkg::DATA_WIDTH - 1; b >= 0; b--) begin
                if (e.gaps && (b % 5 == 0)) begin
                    next_cycle();
                    valid = 1'b0;
                end
                next_cycle();
                check_level(ready, 1'b0, "ready during write");
                wD    = e.wdata[w][b];
                valid = 1'b1;
                last  = (w == e.len - 1);
            end
        end
        next_cycle();
        wD    = 1'b0;
        valid = 1'b0;
        last  = 1'b0;
    endtask

    task automatic read_words(input entry_t e);
        logic [serial_slave_pkg::DATA_WIDTH-1:0] got;
        int w;
        int b;
        int waited;
        for (w = 0; w < e.len; w++) begin
            waited = 0;
            while (ready !== 1'b1 && waited < READY_TIMEOUT) begin
                next_cycle();
                waited++;
            end
            if (ready !== 1'b1) begin
                timeouts++;
                $display("timeout: no ready for word %0d of the read at 0x%02h by %0t ns",
                         w, e.addr, $time);
                last = 1'b0;
                return;
            end
            // last covers the whole final word of a burst, up to its done edge
            last = (e.len > 4'd1) && (w == e.len - 1);
            got  = '0;
            for (b = 0; b < serial_slave_pkg::DATA_WIDTH; b++) begin
                if (b > 0) begin
                    next_cycle();
                end
                check_level(ready, 1'b1, "ready inside a read word");
                got = {got[serial_slave_pkg::DATA_WIDTH-2:0], rD};
            end
            check_word(got, e.exp[w], $sformatf("read word %0d at 0x%02h", w, e.addr + w));
            next_cycle();
        end
        last = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        send_header(e);
        if (e.is_write) begin
            write_words(e);
        end else if (accepted(e)) begin
            read_words(e);
        end else begin
            observe_idle(IDLE_WINDOW);
        end
        observe_idle(3);
    endtask

    initial begin
        int i;
        control  = 1'b0;
        wD       = 1'b0;
        valid    = 1'b0;
        last     = 1'b0;
        rstN     = 1'b0;
        errors   = 0;
        timeouts = 0;
        seed     = 84715;
        void'($urandom(seed));
        build_table();
        fill_expected();
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        observe_idle(10);
        for (i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(tbl[i]);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- serial_slave.f
serial_slave_pkg.sv
header_receiver.sv
write_deserializer.sv
slave_controller.sv
slave_memory.sv
read_serializer.sv
serial_slave_top.sv
serial_slave_checker.sv
tb_serial_slave.sv

//--- Bender.yml
package:
  name: serial_slave

sources:
  - serial_slave_pkg.sv
  - header_receiver.sv
  - write_deserializer.sv
  - slave_controller.sv
  - slave_memory.sv
  - read_serializer.sv
  - serial_slave_top.sv
  - target: test
    files:
      - serial_slave_checker.sv
      - tb_serial_slave.sv
